// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - verilog/rvPkg.sv
  - verilog/fetchStage.sv
  - verilog/decodeStage.sv
  - verilog/idExRegister.sv
  - verilog/executeStage.sv
  - verilog/memoryStage.sv
  - verilog/hazardUnit.sv
  - verilog/rvCore.sv
  - target: test
    files:
      - tests/rvCore_assertions.sv
      - tests/rvCoreTb.sv

// ==== sim.f ====
verilog/rvPkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/idExRegister.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/hazardUnit.sv
verilog/rvCore.sv
tests/rvCore_assertions.sv
tests/rvCoreTb.sv

// ==== tests/rvCoreTb.sv ====
`timescale 1ns/1ps

module rvCoreTb import rvPkg::*; ();

    localparam logic [6:0] OP_R     = 7'h33;
    localparam logic [6:0] OP_I     = 7'h13;
    localparam logic [6:0] OP_LD    = 7'h03;
    localparam logic [6:0] OP_ST    = 7'h23;
    localparam logic [6:0] OP_BR    = 7'h63;
    localparam logic [6:0] OP_JAL   = 7'h6f;
    localparam logic [6:0] OP_JALR  = 7'h67;
    localparam logic [6:0] OP_AUIPC = 7'h17;
    // jal to itself with x0 as link ends every program
    localparam word_t SELF_JUMP = 32'h0000_006f;

    localparam int SEC_ALU    = 0;
    localparam int SEC_X0     = 1;
    localparam int SEC_MEM    = 2;
    localparam int SEC_BRANCH = 3;
    localparam int SEC_JUMP   = 4;

    logic    clk;
    logic    arstN;
    logic    run;
    logic    progWe;
    word_t   progAddr;
    word_t   progData;
    logic    retireValid;
    regIdx_t retireRd;
    word_t   retireData;

    word_t       prog [256];
    int          secOf [256];
    int          progLen;
    regIdx_t     expRd [$];
    word_t       expVal [$];
    word_t       expPc [$];
    int          expCount;
    int          retired;
    int          cycles;
    int          cycleLimit;
    int unsigned seed = 32'hee33_3795;

    rvCore #(
        .IMEM_WORDS(256),
        .DMEM_WORDS(256)
    ) i_rvCore (
        .clk        (clk),
        .arstN      (arstN),
        .run        (run),
        .progWe     (progWe),
        .progAddr   (progAddr),
        .progData   (progData),
        .retireValid(retireValid),
        .retireRd   (retireRd),
        .retireData (retireData)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t encR(input logic [6:0] f7, input regIdx_t rs2, input regIdx_t rs1,
                                   input logic [2:0] f3, input regIdx_t rd);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic word_t encI(input logic [11:0] imm, input regIdx_t rs1,
                                   input logic [2:0] f3, input regIdx_t rd,
                                   input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t encS(input logic [11:0] imm, input regIdx_t rs2,
                                   input regIdx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_ST};
    endfunction

    function automatic word_t encB(input logic [12:0] imm, input regIdx_t rs2,
                                   input regIdx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BR};
    endfunction

    function automatic word_t encJ(input logic [20:0] imm, input regIdx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function automatic regIdx_t randReg(input int lo, input int hi);
        word_t r;
        r = $urandom_range(hi, lo);
        return r[4:0];
    endfunction

    function automatic logic [2:0] f3Of(input int k);
        case (k)
            0, 1:    return 3'd0;
            2:       return 3'd1;
            3:       return 3'd2;
            4:       return 3'd4;
            5:       return 3'd5;
            6:       return 3'd6;
            default: return 3'd7;
        endcase
    endfunction

    function automatic string secName(input int sec);
        case (sec)
            SEC_ALU:    return "alu";
            SEC_X0:     return "x0";
            SEC_MEM:    return "load-store";
            SEC_BRANCH: return "branch";
            default:    return "jump";
        endcase
    endfunction

    task automatic emit(input word_t instr, input int sec);
        prog[progLen]  = instr;
        secOf[progLen] = sec;
        progLen++;
    endtask

    task automatic buildProgram();
        regIdx_t     rd;
        regIdx_t     rs1;
        regIdx_t     rs2;
        regIdx_t     lastRd;
        logic [2:0]  f3;
        logic [11:0] imm;
        word_t       rnd;
        word_t       base;
        word_t       off;
        int          k;
        progLen = 0;
        for (regIdx_t r = 1; r < 16; r++) begin
            rnd = $urandom;
            emit(encI(rnd[11:0], r, 3'd0, r, OP_I), SEC_ALU);
        end
        // widen a few so the sign bit gets exercised
        emit(encI(12'd20, 5'd3, 3'd1, 5'd3, OP_I), SEC_ALU);
        emit(encI(12'd25, 5'd7, 3'd1, 5'd7, OP_I), SEC_ALU);
        emit(encR(7'h20, 5'd7, 5'd0, 3'd0, 5'd11), SEC_ALU);
        lastRd = 5'd11;
        for (int n = 0; n < 24; n++) begin
            rd  = randReg(0, 15);
            rs1 = ($urandom % 2 == 0) ? lastRd : randReg(0, 15);
            rs2 = randReg(0, 15);
            k   = $urandom % 8;
            f3  = f3Of(k);
            if ($urandom % 2 == 0) begin
                emit(encR((k == 1) ? 7'h20 : 7'h00, rs2, rs1, f3, rd), SEC_ALU);
            end else begin
                rnd = $urandom;
                imm = (f3 == 3'd1 || f3 == 3'd5) ? {7'd0, rnd[4:0]} : rnd[11:0];
                emit(encI(imm, rs1, f3, rd, OP_I), SEC_ALU);
            end
            lastRd = rd;
        end
        emit(encI(12'd77, 5'd5, 3'd0, 5'd0, OP_I), SEC_X0);
        emit(encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd0), SEC_X0);
        emit(encR(7'h00, 5'd3, 5'd0, 3'd0, 5'd9), SEC_X0);
        emit(encR(7'h00, 5'd0, 5'd0, 3'd6, 5'd10), SEC_X0);
        for (int n = 0; n < 3; n++) begin
            base = 32'd64 + 32'd16 * ($urandom % 8);
            off  = 32'd4 * ($urandom % 4);
            emit(encI(base[11:0], 5'd0, 3'd0, 5'd20, OP_I), SEC_MEM);
            emit(encS(off[11:0], randReg(1, 15), 5'd20), SEC_MEM);
            emit(encI(off[11:0], 5'd20, 3'd2, 5'd21, OP_LD), SEC_MEM);
            // use right behind the load forces the stall
            emit(encR(7'h00, 5'd1, 5'd21, 3'd0, 5'd22), SEC_MEM);
            emit(encS(off[11:0] + 12'd16, 5'd22, 5'd20), SEC_MEM);
            emit(encI(off[11:0] + 12'd16, 5'd20, 3'd2, 5'd23, OP_LD), SEC_MEM);
            emit(encR(7'h00, 5'd2, 5'd23, 3'd6, 5'd24), SEC_MEM);
        end
        for (int n = 0; n < 6; n++) begin
            rs1 = randReg(1, 15);
            rs2 = ($urandom % 2 == 0) ? rs1 : randReg(1, 15);
            f3  = ($urandom % 2 == 0) ? 3'd0 : 3'd1;
            emit(encB(13'd12, rs2, rs1, f3), SEC_BRANCH);
            emit(encI(12'd100 + n[11:0], 5'd0, 3'd0, 5'd23, OP_I), SEC_BRANCH);
            emit(encI(12'd5, 5'd23, 3'd0, 5'd24, OP_I), SEC_BRANCH);
            emit(encR(7'h00, rs1, 5'd24, 3'd4, 5'd25), SEC_BRANCH);
        end
        emit(encJ(21'd12, 5'd1), SEC_JUMP);
        emit(encI(12'd99, 5'd0, 3'd0, 5'd23, OP_I), SEC_JUMP);
        emit(encI(12'd98, 5'd0, 3'd0, 5'd24, OP_I), SEC_JUMP);
        emit(encR(7'h00, 5'd0, 5'd1, 3'd0, 5'd25), SEC_JUMP);
        rnd = $urandom;
        emit({rnd[19:0], 5'd26, OP_AUIPC}, SEC_JUMP);
        emit({20'd0, 5'd27, OP_AUIPC}, SEC_JUMP);
        // bit 0 of the odd offset is dropped from the target
        emit(encI(12'd17, 5'd27, 3'd0, 5'd28, OP_JALR), SEC_JUMP);
        emit(encI(12'd97, 5'd0, 3'd0, 5'd23, OP_I), SEC_JUMP);
        emit(encI(12'd96, 5'd0, 3'd0, 5'd24, OP_I), SEC_JUMP);
        emit(encR(7'h00, 5'd26, 5'd28, 3'd0, 5'd29), SEC_JUMP);
        emit(SELF_JUMP, SEC_JUMP);
    endtask

    function automatic word_t aluRef(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return a >> b[4:0];
            3'd6:    return a | b;
            3'd7:    return a & b;
            default: return '0;
        endcase
    endfunction

    // ISA model that queues every non-x0 write and returns the executed count
    function automatic int modelRun();
        word_t      rf [32];
        word_t      dm [256];
        word_t      pc;
        word_t      ins;
        word_t      a;
        word_t      b;
        word_t      res;
        word_t      next;
        word_t      addr;
        word_t      immI;
        word_t      immS;
        word_t      immB;
        word_t      immJ;
        logic [2:0] f3;
        regIdx_t    rd;
        logic       wr;
        int         n;
        for (int i = 0; i < 32; i++) begin
            rf[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            dm[i] = '0;
        end
        pc = '0;
        n  = 0;
        while (prog[pc[9:2]] != SELF_JUMP && n < 1000) begin
            ins  = prog[pc[9:2]];
            f3   = ins[14:12];
            rd   = ins[11:7];
            a    = rf[ins[19:15]];
            b    = rf[ins[24:20]];
            immI = {{20{ins[31]}}, ins[31:20]};
            immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            next = pc + 32'd4;
            wr   = 1'b1;
            res  = '0;
            case (ins[6:0])
                OP_R:  res = aluRef(f3, ins[30], a, b);
                OP_I:  res = aluRef(f3, 1'b0, a, immI);
                OP_LD: begin
                    addr = a + immI;
                    res  = dm[addr[9:2]];
                end
                OP_ST: begin
                    addr = a + immS;
                    dm[addr[9:2]] = b;
                    wr = 1'b0;
                end
                OP_BR: begin
                    if ((f3 == 3'd0) ? (a == b) : (a != b)) begin
                        next = pc + immB;
                    end
                    wr = 1'b0;
                end
                OP_JAL: begin
                    res  = pc + 32'd4;
                    next = pc + immJ;
                end
                OP_JALR: begin
                    res  = pc + 32'd4;
                    next = (a + immI) & ~32'd1;
                end
                OP_AUIPC: res = pc + {ins[31:12], 12'd0};
                default:  wr = 1'b0;
            endcase
            if (wr && rd != '0) begin
                rf[rd] = res;
                expRd.push_back(rd);
                expVal.push_back(res);
                expPc.push_back(pc);
            end
            pc = next;
            n++;
        end
        return n;
    endfunction

    task automatic abortRun();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkEq(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    always @(negedge clk) begin : retireCompare
        word_t   pcNow;
        regIdx_t rdNow;
        word_t   valNow;
        string   name;
        if (retireValid === 1'b1) begin
            if (expRd.size() == 0) begin
                $display("core retired a write to x%0d after the last expected write",
                         retireRd);
                abortRun();
            end else begin
                pcNow  = expPc.pop_front();
                rdNow  = expRd.pop_front();
                valNow = expVal.pop_front();
                name   = $sformatf("%s retire %0d", secName(secOf[pcNow[9:2]]), retired);
                checkEq({name, " rd"}, rdNow, retireRd);
                checkEq({name, " data"}, valNow, retireData);
                retired++;
            end
        end
    end

    always @(posedge clk) begin
        if (run) begin
            cycles++;
            if (cycles >= cycleLimit) begin
                $display("timeout, core stopped retiring after %0d cycles (%0d of %0d writes)",
                         cycles, retired, expCount);
                abortRun();
            end
        end
    end

    initial begin
        arstN    = 1'b0;
        run      = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        retired  = 0;
        cycles   = 0;
        void'($urandom(seed));
        buildProgram();
        cycleLimit = 4 * modelRun() + 50;
        expCount   = expRd.size();
        repeat (2) @(negedge clk);
        arstN = 1'b1;
        for (int i = 0; i < progLen; i++) begin
            @(negedge clk);
            progWe   = 1'b1;
            progAddr = i * 4;
            progData = prog[i];
        end
        @(negedge clk);
        progWe = 1'b0;
        @(negedge clk);
        run = 1'b1;
        while (retired < expCount) begin
            @(negedge clk);
        end
        // the self-jump must not retire anything more
        repeat (10) @(negedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== tests/rvCore_assertions.sv ====
`timescale 1ns/1ps

module rvCore_assertions import rvPkg::*; (
    input logic    clk,
    input logic    arstN,
    input logic    run,
    input logic    retireValid,
    input regIdx_t retireRd,
    input word_t   retireData,
    input logic    memWriteE,
    input logic    flushE,
    input logic    stallD
);

    // a retiring write carries a known register and value
    retireKnown: assert property (@(posedge clk) disable iff (!arstN)
        retireValid |-> !$isunknown({retireRd, retireData}))
        else $error("retire strobe raised with an unknown register or value");

    storeNotDropped: assert property (@(posedge clk) disable iff (!arstN)
        memWriteE |-> (!flushE && run))
        else $error("store in execute while execute is flushed or held");

    // the bubble behind a load clears the hazard
    loadUseOneCycle: assert property (@(posedge clk) disable iff (!arstN)
        stallD |=> !stallD)
        else $error("load-use stall held for more than one cycle");

endmodule

bind rvCore rvCore_assertions i_rvCoreAssertions (
    .clk        (clk),
    .arstN      (arstN),
    .run        (run),
    .retireValid(retireValid),
    .retireRd   (retireRd),
    .retireData (retireData),
    .memWriteE  (memWriteE),
    .flushE     (flushE),
    .stallD     (stallD)
);

// ==== verilog/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage import rvPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  word_t      instrD,
    input  logic       regWriteW,
    input  regIdx_t    rdW,
    input  word_t      resultW,
    output logic       regWriteD,
    output resultSrc_t resultSrcD,
    output logic       memWriteD,
    output logic       jumpD,
    output logic       branchD,
    output aluOp_t     aluControlD,
    output logic       aluSrcAD,
    output logic       aluSrcBD,
    output logic       jalSrcD,
    output logic [2:0] funct3D,
    output word_t      rd1D,
    output word_t      rd2D,
    output regIdx_t    rdD,
    output regIdx_t    rs1D,
    output regIdx_t    rs2D,
    output word_t      immExtD
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    logic [6:0] opcode;
    logic       useRs1;
    logic       useRs2;
    aluOp_t     aluFunct;
    word_t      regs [32];

    assign opcode  = instrD[6:0];
    assign funct3D = instrD[14:12];
    assign rdD     = instrD[11:7];
    // unused source fields read as x0 so they raise no false hazards
    assign rs1D    = useRs1 ? instrD[19:15] : '0;
    assign rs2D    = useRs2 ? instrD[24:20] : '0;

    always_comb begin
        case (funct3D)
            3'b000:  aluFunct = (opcode == OPC_OP && instrD[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  aluFunct = ALU_SLL;
            3'b010:  aluFunct = ALU_SLT;
            3'b100:  aluFunct = ALU_XOR;
            3'b101:  aluFunct = ALU_SRL;
            3'b110:  aluFunct = ALU_OR;
            3'b111:  aluFunct = ALU_AND;
            default: aluFunct = ALU_ADD;
        endcase
    end

    // unsupported opcodes fall through as a bubble
    always_comb begin
        regWriteD   = 1'b0;
        resultSrcD  = RES_ALU;
        memWriteD   = 1'b0;
        jumpD       = 1'b0;
        branchD     = 1'b0;
        aluControlD = ALU_ADD;
        aluSrcAD    = 1'b0;
        aluSrcBD    = 1'b0;
        jalSrcD     = 1'b0;
        useRs1      = 1'b0;
        useRs2      = 1'b0;
        immExtD     = '0;
        case (opcode)
            OPC_OP: begin
                regWriteD   = 1'b1;
                aluControlD = aluFunct;
                useRs1      = 1'b1;
                useRs2      = 1'b1;
            end
            OPC_OP_IMM: begin
                regWriteD   = 1'b1;
                aluControlD = aluFunct;
                aluSrcBD    = 1'b1;
                useRs1      = 1'b1;
                immExtD     = {{20{instrD[31]}}, instrD[31:20]};
            end
            OPC_LOAD: begin
                regWriteD  = 1'b1;
                resultSrcD = RES_MEM;
                aluSrcBD   = 1'b1;
                useRs1     = 1'b1;
                immExtD    = {{20{instrD[31]}}, instrD[31:20]};
            end
            OPC_STORE: begin
                memWriteD = 1'b1;
                aluSrcBD  = 1'b1;
                useRs1    = 1'b1;
                useRs2    = 1'b1;
                immExtD   = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            end
            OPC_BRANCH: begin
                branchD     = 1'b1;
                aluControlD = ALU_SUB;
                useRs1      = 1'b1;
                useRs2      = 1'b1;
                immExtD     = {{20{instrD[31]}}, instrD[7], instrD[30:25],
                               instrD[11:8], 1'b0};
            end
            OPC_JAL: begin
                regWriteD  = 1'b1;
                resultSrcD = RES_PC4;
                jumpD      = 1'b1;
                immExtD    = {{12{instrD[31]}}, instrD[19:12], instrD[20],
                              instrD[30:21], 1'b0};
            end
            OPC_JALR: begin
                regWriteD  = 1'b1;
                resultSrcD = RES_PC4;
                jumpD      = 1'b1;
                jalSrcD    = 1'b1;
                useRs1     = 1'b1;
                immExtD    = {{20{instrD[31]}}, instrD[31:20]};
            end
            OPC_AUIPC: begin
                regWriteD = 1'b1;
                aluSrcAD  = 1'b1;
                aluSrcBD  = 1'b1;
                immExtD   = {instrD[31:12], 12'b0};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWriteW && rdW != '0) begin
            regs[rdW] <= resultW;
        end
    end

    // write-first, x0 stays zero since it is never written
    assign rd1D = (regWriteW && rdW == rs1D && rs1D != '0) ? resultW : regs[rs1D];
    assign rd2D = (regWriteW && rdW == rs2D && rs2D != '0) ? resultW : regs[rs2D];

endmodule

// ==== verilog/executeStage.sv ====
`timescale 1ns/1ps

module executeStage import rvPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  logic       regWriteE,
    input  resultSrc_t resultSrcE,
    input  logic       memWriteE,
    input  logic       jumpE,
    input  logic       branchE,
    input  aluOp_t     aluControlE,
    input  logic       aluSrcAE,
    input  logic       aluSrcBE,
    input  logic       jalSrcE,
    input  logic [2:0] funct3E,
    input  word_t      rd1E,
    input  word_t      rd2E,
    input  regIdx_t    rdE,
    input  word_t      immExtE,
    input  word_t      pcE,
    input  word_t      pcPlusE,
    input  fwdSel_t    fwdAE,
    input  fwdSel_t    fwdBE,
    input  word_t      resultW,
    output logic       pcSrcE,
    output word_t      pcTargetE,
    output logic       regWriteM,
    output resultSrc_t resultSrcM,
    output logic       memWriteM,
    output word_t      aluResultM,
    output word_t      writeDataM,
    output regIdx_t    rdM,
    output word_t      pcPlusM
);

    word_t srcAFwd;
    word_t srcBFwd;
    word_t srcA;
    word_t srcB;
    word_t aluResult;
    word_t targetSum;
    logic  zero;

    always_comb begin
        case (fwdAE)
            FWD_MEM: srcAFwd = aluResultM;
            FWD_WB:  srcAFwd = resultW;
            default: srcAFwd = rd1E;
        endcase
        case (fwdBE)
            FWD_MEM: srcBFwd = aluResultM;
            FWD_WB:  srcBFwd = resultW;
            default: srcBFwd = rd2E;
        endcase
    end

    assign srcA = aluSrcAE ? pcE : srcAFwd;
    assign srcB = aluSrcBE ? immExtE : srcBFwd;

    always_comb begin
        case (aluControlE)
            ALU_SUB: aluResult = srcA - srcB;
            ALU_AND: aluResult = srcA & srcB;
            ALU_OR:  aluResult = srcA | srcB;
            ALU_XOR: aluResult = srcA ^ srcB;
            ALU_SLT: aluResult = {31'b0, $signed(srcA) < $signed(srcB)};
            ALU_SLL: aluResult = srcA << srcB[4:0];
            ALU_SRL: aluResult = srcA >> srcB[4:0];
            default: aluResult = srcA + srcB;
        endcase
    end

    // funct3[0] picks bne over beq
    assign zero      = (aluResult == '0);
    assign pcSrcE    = jumpE || (branchE && (funct3E[0] ? !zero : zero));
    assign targetSum = (jalSrcE ? srcAFwd : pcE) + immExtE;
    assign pcTargetE = {targetSum[31:1], 1'b0};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regWriteM  <= 1'b0;
            resultSrcM <= RES_ALU;
            memWriteM  <= 1'b0;
        end else begin
            regWriteM  <= regWriteE;
            resultSrcM <= resultSrcE;
            memWriteM  <= memWriteE;
        end
    end

    // jumps carry the link value so forwarding from memory sees it
    always_ff @(posedge clk) begin
        aluResultM <= jumpE ? pcPlusE : aluResult;
        writeDataM <= srcBFwd;
        rdM        <= rdE;
        pcPlusM    <= pcPlusE;
    end

endmodule

// ==== verilog/fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage import rvPkg::*; #(
    parameter int IMEM_WORDS = 256
) (
    input  logic  clk,
    input  logic  arstN,
    input  logic  run,
    input  logic  stallF,
    input  logic  stallD,
    input  logic  flushD,
    input  logic  pcSrcE,
    input  word_t pcTargetE,
    input  logic  progWe,
    input  word_t progAddr,
    input  word_t progData,
    output word_t instrD,
    output word_t pcD,
    output word_t pcPlusD
);

    localparam int AW = $clog2(IMEM_WORDS);
    // addi x0, x0, 0
    localparam word_t NOP = 32'h0000_0013;

    word_t imem [IMEM_WORDS];
    word_t pcF;
    word_t pcPlusF;
    word_t instrF;

    assign pcPlusF = pcF + 32'd4;
    assign instrF  = imem[pcF[AW+1:2]];

    // program load only while stopped
    always_ff @(posedge clk) begin
        if (progWe && !run) begin
            imem[progAddr[AW+1:2]] <= progData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcF <= '0;
        end else if (!run) begin
            pcF <= '0;
        end else if (!stallF) begin
            pcF <= pcSrcE ? pcTargetE : pcPlusF;
        end
    end

    // fetch to decode, a stopped core feeds bubbles
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instrD  <= NOP;
            pcD     <= '0;
            pcPlusD <= '0;
        end else if (flushD || !run) begin
            instrD  <= NOP;
            pcD     <= '0;
            pcPlusD <= '0;
        end else if (!stallD) begin
            instrD  <= instrF;
            pcD     <= pcF;
            pcPlusD <= pcPlusF;
        end
    end

endmodule

// ==== verilog/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit import rvPkg::*; (
    input  regIdx_t    rs1D,
    input  regIdx_t    rs2D,
    input  regIdx_t    rs1E,
    input  regIdx_t    rs2E,
    input  regIdx_t    rdE,
    input  resultSrc_t resultSrcE,
    input  logic       pcSrcE,
    input  regIdx_t    rdM,
    input  logic       regWriteM,
    input  regIdx_t    rdW,
    input  logic       regWriteW,
    output fwdSel_t    fwdAE,
    output fwdSel_t    fwdBE,
    output logic       stallF,
    output logic       stallD,
    output logic       flushD,
    output logic       flushE
);

    logic lwStall;

    // memory stage is younger, so it wins over writeback
    always_comb begin
        fwdAE = FWD_RF;
        if (rs1E != '0 && regWriteM && rs1E == rdM) begin
            fwdAE = FWD_MEM;
        end else if (rs1E != '0 && regWriteW && rs1E == rdW) begin
            fwdAE = FWD_WB;
        end
        fwdBE = FWD_RF;
        if (rs2E != '0 && regWriteM && rs2E == rdM) begin
            fwdBE = FWD_MEM;
        end else if (rs2E != '0 && regWriteW && rs2E == rdW) begin
            fwdBE = FWD_WB;
        end
    end

    assign lwStall = (resultSrcE == RES_MEM) && (rdE != '0) &&
                     ((rs1D == rdE) || (rs2D == rdE));

    assign stallF = lwStall;
    assign stallD = lwStall;
    assign flushD = pcSrcE;
    assign flushE = lwStall || pcSrcE;

endmodule

// ==== verilog/idExRegister.sv ====
`timescale 1ns/1ps

module idExRegister import rvPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  logic       stall,
    input  logic       clr,
    // control
    input  logic       regWriteD,
    input  resultSrc_t resultSrcD,
    input  logic       memWriteD,
    input  logic       jumpD,
    input  logic       branchD,
    input  aluOp_t     aluControlD,
    input  logic       aluSrcAD,
    input  logic       aluSrcBD,
    input  logic       jalSrcD,
    input  logic [2:0] funct3D,
    // operands and indices
    input  word_t      rd1D,
    input  word_t      rd2D,
    input  regIdx_t    rdD,
    input  regIdx_t    rs1D,
    input  regIdx_t    rs2D,
    input  word_t      immExtD,
    input  word_t      pcD,
    input  word_t      pcPlusD,
    output logic       regWriteE,
    output resultSrc_t resultSrcE,
    output logic       memWriteE,
    output logic       jumpE,
    output logic       branchE,
    output aluOp_t     aluControlE,
    output logic       aluSrcAE,
    output logic       aluSrcBE,
    output logic       jalSrcE,
    output logic [2:0] funct3E,
    output word_t      rd1E,
    output word_t      rd2E,
    output regIdx_t    rdE,
    output regIdx_t    rs1E,
    output regIdx_t    rs2E,
    output word_t      immExtE,
    output word_t      pcE,
    output word_t      pcPlusE
);

    // a cleared entry is a bubble with no write and no store
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            {regWriteE, resultSrcE, memWriteE, jumpE, branchE, aluControlE,
             aluSrcAE, aluSrcBE, jalSrcE, funct3E, rd1E, rd2E, rdE, rs1E, rs2E,
             immExtE, pcE, pcPlusE} <= '0;
        end else if (clr) begin
            {regWriteE, resultSrcE, memWriteE, jumpE, branchE, aluControlE,
             aluSrcAE, aluSrcBE, jalSrcE, funct3E, rd1E, rd2E, rdE, rs1E, rs2E,
             immExtE, pcE, pcPlusE} <= '0;
        end else if (!stall) begin
            {regWriteE, resultSrcE, memWriteE, jumpE, branchE, aluControlE,
             aluSrcAE, aluSrcBE, jalSrcE, funct3E, rd1E, rd2E, rdE, rs1E, rs2E,
             immExtE, pcE, pcPlusE} <=
            {regWriteD, resultSrcD, memWriteD, jumpD, branchD, aluControlD,
             aluSrcAD, aluSrcBD, jalSrcD, funct3D, rd1D, rd2D, rdD, rs1D, rs2D,
             immExtD, pcD, pcPlusD};
        end
    end

endmodule

// ==== verilog/memoryStage.sv ====
`timescale 1ns/1ps

module memoryStage import rvPkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input  logic       clk,
    input  logic       arstN,
    input  logic       regWriteM,
    input  resultSrc_t resultSrcM,
    input  logic       memWriteM,
    input  word_t      aluResultM,
    input  word_t      writeDataM,
    input  regIdx_t    rdM,
    input  word_t      pcPlusM,
    output logic       regWriteW,
    output regIdx_t    rdW,
    output word_t      resultW
);

    localparam int AW = $clog2(DMEM_WORDS);

    word_t dmem [DMEM_WORDS];
    word_t readDataM;
    word_t resultM;

    // word index, low two bits and upper bits dropped
    assign readDataM = dmem[aluResultM[AW+1:2]];

    always_ff @(posedge clk) begin
        if (memWriteM) begin
            dmem[aluResultM[AW+1:2]] <= writeDataM;
        end
    end

    always_comb begin
        case (resultSrcM)
            RES_MEM: resultM = readDataM;
            RES_PC4: resultM = pcPlusM;
            default: resultM = aluResultM;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regWriteW <= 1'b0;
        end else begin
            regWriteW <= regWriteM;
        end
    end

    always_ff @(posedge clk) begin
        rdW     <= rdM;
        resultW <= resultM;
    end

endmodule

// ==== verilog/rvCore.sv ====
`timescale 1ns/1ps

module rvCore import rvPkg::*; #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    run,
    input  logic    progWe,
    input  word_t   progAddr,
    input  word_t   progData,
    output logic    retireValid,
    output regIdx_t retireRd,
    output word_t   retireData
);

    // fetch to decode
    word_t      instrD, pcD, pcPlusD;

    // decode
    logic       regWriteD, memWriteD, jumpD, branchD, aluSrcAD, aluSrcBD, jalSrcD;
    resultSrc_t resultSrcD;
    aluOp_t     aluControlD;
    logic [2:0] funct3D;
    word_t      rd1D, rd2D, immExtD;
    regIdx_t    rdD, rs1D, rs2D;

    // execute
    logic       regWriteE, memWriteE, jumpE, branchE, aluSrcAE, aluSrcBE, jalSrcE;
    resultSrc_t resultSrcE;
    aluOp_t     aluControlE;
    logic [2:0] funct3E;
    word_t      rd1E, rd2E, immExtE, pcE, pcPlusE;
    regIdx_t    rdE, rs1E, rs2E;
    logic       pcSrcE;
    word_t      pcTargetE;

    // memory and writeback
    logic       regWriteM, memWriteM, regWriteW;
    resultSrc_t resultSrcM;
    word_t      aluResultM, writeDataM, pcPlusM, resultW;
    regIdx_t    rdM, rdW;

    // hazard control
    fwdSel_t    fwdAE, fwdBE;
    logic       stallF, stallD, flushD, flushE;

    fetchStage #(.IMEM_WORDS(IMEM_WORDS)) i_fetchStage (.*);

    decodeStage i_decodeStage (.*);

    // execute holds its bubble while the core is stopped
    idExRegister i_idExRegister (
        .stall (!run),
        .clr   (flushE),
        .*
    );

    executeStage i_executeStage (.*);

    memoryStage #(.DMEM_WORDS(DMEM_WORDS)) i_memoryStage (.*);

    hazardUnit i_hazardUnit (.*);

    assign retireValid = regWriteW && (rdW != '0);
    assign retireRd    = rdW;
    assign retireData  = resultW;

endmodule

// ==== verilog/rvPkg.sv ====
package rvPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIdx_t;
    typedef logic [2:0]  aluOp_t;
    typedef logic [1:0]  resultSrc_t;
    typedef logic [1:0]  fwdSel_t;

    // alu operations
    localparam aluOp_t ALU_ADD = 3'd0;
    localparam aluOp_t ALU_SUB = 3'd1;
    localparam aluOp_t ALU_AND = 3'd2;
    localparam aluOp_t ALU_OR  = 3'd3;
    localparam aluOp_t ALU_XOR = 3'd4;
    localparam aluOp_t ALU_SLT = 3'd5;
    localparam aluOp_t ALU_SLL = 3'd6;
    localparam aluOp_t ALU_SRL = 3'd7;

    // writeback source
    localparam resultSrc_t RES_ALU = 2'd0;
    localparam resultSrc_t RES_MEM = 2'd1;
    localparam resultSrc_t RES_PC4 = 2'd2;

    // operand forwarding into execute
    localparam fwdSel_t FWD_RF  = 2'd0;
    localparam fwdSel_t FWD_WB  = 2'd1;
    localparam fwdSel_t FWD_MEM = 2'd2;

endpackage
